/* source/gamePkg.sv */
package gamePkg;

	typedef enum logic [2:0] {
		Wait,
		Drop,
		DropNoReset,
		Falling,
		Hold,
		Bottom,
		Paused,
		EndScreen
	} gameState;

	typedef enum logic [2:0] {
		None,
		Start,
		Pause,
		Resume,
		HoldPiece,
		Quit
	} gameCmd;

	typedef enum logic [1:0] {
		Play = 2'd0,
		PauseScreen = 2'd1,
		Title = 2'd2,
		Over = 2'd3
	} screenCode;

	typedef struct packed {
		logic [15:0] shape; // 4x4 mask, top row in the high nibble.
		logic [5:0] sprite;
	} pieceT;

	typedef struct packed {
		gameState state;
		screenCode screen;
		logic paused;
		logic resetBlocks;
		logic canHold;
		logic [15:0] drops;
		logic [7:0] holds;
		logic [7:0] games;
	} statusT;

	localparam logic [7:0] KeyStart = 8'h2C; // Space.
	localparam logic [7:0] KeyPause = 8'h13; // P.
	localparam logic [7:0] KeyResume = 8'h18; // U.
	localparam logic [7:0] KeyHold = 8'h2B; // Tab.
	localparam logic [7:0] KeyQuit = 8'h29; // Esc.

	localparam int NumShapes = 7;

	// I, O, T, S, Z, J, L.
	localparam logic [15:0] PieceShapes [NumShapes] = '{
		16'h0F00,
		16'h0660,
		16'h0E40,
		16'h06C0,
		16'h0C60,
		16'h0E20,
		16'h0E80
	};

endpackage

/* source/busPkg.sv */
package busPkg;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [2:0] adr;
		logic [31:0] dat;
		logic [3:0] sel; // Byte lanes, not decoded.
	} wbReq;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wbRsp;

	localparam logic [2:0] AdrKey = 3'd0;
	localparam logic [2:0] AdrStatus = 3'd1;
	localparam logic [2:0] AdrCurrent = 3'd2;
	localparam logic [2:0] AdrHold = 3'd3;
	localparam logic [2:0] AdrQueue = 3'd4;
	localparam logic [2:0] AdrCount = 3'd5;

endpackage

/* source/hostPort.sv */
`timescale 1ns/1ps

module hostPort (
	input logic Clk,
	input logic rst,
	input busPkg::wbReq bus,
	input gamePkg::statusT status,
	input gamePkg::pieceT current,
	input gamePkg::pieceT queued,
	input gamePkg::pieceT held,
	output busPkg::wbRsp rsp,
	output gamePkg::gameCmd cmd
);
	import gamePkg::*;
	import busPkg::*;

	logic [7:0] keycode;
	logic ack;
	logic request;
	logic [31:0] readData;
	logic [31:0] datReg;
	gameCmd cmdIn;

	// A cycle already acked is not taken again.
	assign request = bus.cyc && bus.stb && !ack;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			keycode <= 8'h00;
			cmd <= None;
		end
		else
		begin
			ack <= request;
			cmd <= cmdIn; // Seen one cycle after the key write is acked.
			if (request && bus.we && bus.adr == AdrKey)
				keycode <= bus.dat[7:0];
		end
	end

	always_ff @(posedge Clk)
	begin
		if (request)
			datReg <= readData;
	end

	// Key stays active until the host clears it.
	always_comb
	begin
		if (keycode == KeyQuit)
			cmdIn = Quit;
		else if (keycode == KeyStart)
			cmdIn = Start;
		else if (keycode == KeyPause)
			cmdIn = Pause;
		else if (keycode == KeyResume)
			cmdIn = Resume;
		else if (keycode == KeyHold)
			cmdIn = HoldPiece;
		else
			cmdIn = None;
	end

	always_comb
	begin
		case (bus.adr)
			AdrKey: readData = {24'h0, keycode};
			AdrStatus: readData = {status.drops, 8'h00, status.state, status.screen,
				status.paused, status.resetBlocks, status.canHold};
			AdrCurrent: readData = {10'h0, current};
			AdrHold: readData = {10'h0, held};
			AdrQueue: readData = {10'h0, queued};
			AdrCount: readData = {status.drops, status.holds, status.games};
			default: readData = 32'h0;
		endcase
	end

	assign rsp.ack = ack;
	assign rsp.dat = datReg;

endmodule

/* source/pieceSource.sv */
`timescale 1ns/1ps

module pieceSource (
	input logic Clk,
	input logic rst,
	input logic pickPiece,
	output gamePkg::pieceT next
);
	import gamePkg::*;

	logic [15:0] lfsr;
	logic feedback;
	logic [2:0] shapeIdx;

	// Taps 16, 14, 13, 11.
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign shapeIdx = 3'(lfsr % 16'(NumShapes));

	always_ff @(posedge Clk)
	begin
		if (rst)
			lfsr <= 16'hACE1; // Any nonzero seed.
		else
			lfsr <= {lfsr[14:0], feedback};
	end

	// Sprite 0 is left for the empty piece.
	always_ff @(posedge Clk)
	begin
		if (pickPiece)
		begin
			next.shape <= PieceShapes[shapeIdx];
			next.sprite <= {3'b000, shapeIdx} + 6'd1;
		end
	end

endmodule

/* source/gameControl.sv */
`timescale 1ns/1ps

module gameControl (
	input logic Clk,
	input logic rst,
	input gamePkg::gameCmd cmd,
	input logic hitBottom,
	input logic endGame,
	input gamePkg::pieceT next,
	output logic pickPiece,
	output logic resetBlocks,
	output logic paused,
	output gamePkg::screenCode screen,
	output gamePkg::gameState state,
	output logic canHold,
	output gamePkg::pieceT current,
	output gamePkg::pieceT queued,
	output gamePkg::pieceT held
);
	import gamePkg::*;

	gameState stateIn;
	logic canHoldIn;
	pieceT currentIn;
	pieceT queuedIn;
	pieceT heldIn;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= Wait;
			canHold <= 1'b1;
			held <= '0; // Empty hold slot.
		end
		else
		begin
			state <= stateIn;
			canHold <= canHoldIn;
			held <= heldIn;
		end
	end

	always_ff @(posedge Clk)
	begin
		current <= currentIn;
		queued <= queuedIn;
	end

	always_comb
	begin
		stateIn = state;
		unique case (state)
			Wait:
				if (cmd == Start)
					stateIn = Drop;
			Drop,
			DropNoReset:
				stateIn = Falling;
			Falling:
			begin
				if (hitBottom)
					stateIn = Bottom;
				else if (cmd == Pause)
					stateIn = Paused;
				else if (cmd == HoldPiece && canHold)
					stateIn = Hold;
				else if (cmd == Quit)
					stateIn = Wait;
			end
			Hold:
				stateIn = DropNoReset;
			Bottom:
				stateIn = endGame ? EndScreen : Drop;
			Paused:
				if (cmd == Resume)
					stateIn = Falling;
			EndScreen:
				if (cmd == Quit)
					stateIn = Wait;
		endcase
	end

	always_comb
	begin
		canHoldIn = canHold;
		currentIn = current;
		queuedIn = queued;
		heldIn = held;
		pickPiece = 1'b0;
		resetBlocks = 1'b0;
		paused = 1'b0;
		screen = Play;

		case (state)
			Wait:
			begin
				pickPiece = 1'b1; // Keep the queue fresh until start.
				resetBlocks = 1'b1;
				paused = 1'b1;
				screen = Title;
				queuedIn = next;
				heldIn = '0;
				canHoldIn = 1'b1;
			end
			Drop:
			begin
				pickPiece = 1'b1;
				resetBlocks = 1'b1;
				currentIn = queued;
				queuedIn = next;
			end
			DropNoReset:
				resetBlocks = 1'b1;
			Hold:
			begin
				heldIn = current;
				canHoldIn = 1'b0; // One hold per piece.
				if (held.shape == '0)
				begin
					pickPiece = 1'b1;
					currentIn = next;
				end
				else
					currentIn = held; // Swap.
			end
			Bottom:
				canHoldIn = 1'b1;
			Paused:
			begin
				paused = 1'b1;
				screen = PauseScreen;
			end
			EndScreen:
			begin
				paused = 1'b1;
				screen = Over;
				resetBlocks = 1'b1;
			end
			default:
				; // Falling keeps everything.
		endcase
	end

endmodule

/* source/gameStatus.sv */
`timescale 1ns/1ps

module gameStatus (
	input logic Clk,
	input logic rst,
	input gamePkg::gameState state,
	input gamePkg::screenCode screen,
	input logic paused,
	input logic resetBlocks,
	input logic canHold,
	output gamePkg::statusT status
);
	import gamePkg::*;

	gameState prevState;
	logic [15:0] drops;
	logic [7:0] holds;
	logic [7:0] games;
	logic dropEntry;
	logic holdEntry;
	logic gameEntry;

	assign dropEntry = (state == Drop) && (prevState != Drop);
	assign holdEntry = (state == Hold) && (prevState != Hold);
	assign gameEntry = dropEntry && (prevState == Wait); // First drop of a game.

	// Counters stick at their maximum.
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			prevState <= Wait;
			drops <= '0;
			holds <= '0;
			games <= '0;
		end
		else
		begin
			prevState <= state;
			if (dropEntry && drops != '1)
				drops <= drops + 16'd1;
			if (holdEntry && holds != '1)
				holds <= holds + 8'd1;
			if (gameEntry && games != '1)
				games <= games + 8'd1;
		end
	end

	always_comb
	begin
		status.state = state;
		status.screen = screen;
		status.paused = paused;
		status.resetBlocks = resetBlocks;
		status.canHold = canHold;
		status.drops = drops;
		status.holds = holds;
		status.games = games;
	end

endmodule

/* source/tetrisTop.sv */
`timescale 1ns/1ps

module tetrisTop (
	input logic Clk,
	input logic rst,
	input busPkg::wbReq bus,
	input logic hitBottom,
	input logic endGame,
	output busPkg::wbRsp rsp,
	output logic resetBlocks,
	output logic paused,
	output gamePkg::screenCode screen
);
	import gamePkg::*;

	gameCmd cmd;
	gameState state;
	statusT status;
	pieceT next;
	pieceT current;
	pieceT queued;
	pieceT held;
	logic pickPiece;
	logic canHold;

	hostPort i_hostPort (
		.Clk(Clk),
		.rst(rst),
		.bus(bus),
		.status(status),
		.current(current),
		.queued(queued),
		.held(held),
		.rsp(rsp),
		.cmd(cmd)
	);

	pieceSource i_pieceSource (
		.Clk(Clk),
		.rst(rst),
		.pickPiece(pickPiece),
		.next(next)
	);

	gameControl i_gameControl (
		.Clk(Clk),
		.rst(rst),
		.cmd(cmd),
		.hitBottom(hitBottom),
		.endGame(endGame),
		.next(next),
		.pickPiece(pickPiece),
		.resetBlocks(resetBlocks),
		.paused(paused),
		.screen(screen),
		.state(state),
		.canHold(canHold),
		.current(current),
		.queued(queued),
		.held(held)
	);

	gameStatus i_gameStatus (
		.Clk(Clk),
		.rst(rst),
		.state(state),
		.screen(screen),
		.paused(paused),
		.resetBlocks(resetBlocks),
		.canHold(canHold),
		.status(status)
	);

endmodule

/* tests/tetris_assertions.sv */
`timescale 1ns/1ps

module tetrisAssertions (
	input logic Clk,
	input logic rst,
	input busPkg::wbReq bus,
	input busPkg::wbRsp rsp,
	input logic paused,
	input gamePkg::screenCode screen
);
	import gamePkg::*;

	ackOneCycle: assert property (@(posedge Clk) disable iff (rst) rsp.ack |=> !rsp.ack)
		else $error("ack stayed high for more than one cycle");

	// Ack answers a request seen on the edge before.
	ackAfterRequest: assert property (@(posedge Clk) disable iff (rst)
		rsp.ack |-> $past(bus.cyc && bus.stb))
		else $error("ack without a cyc and stb request");

	pausedOffPlay: assert property (@(posedge Clk) disable iff (rst)
		(screen != Play) |-> paused)
		else $error("paused low on a screen other than Play");

endmodule

bind tetrisTop tetrisAssertions i_tetrisAssertions (
	.Clk(Clk),
	.rst(rst),
	.bus(bus),
	.rsp(rsp),
	.paused(paused),
	.screen(screen)
);

/* tests/tetrisTb.sv */
`timescale 1ns/1ps

module tetrisTb;
	import busPkg::*;
	import gamePkg::*;

	logic Clk;
	logic rst;
	wbReq bus;
	wbRsp rsp;
	logic hitBottom;
	logic endGame;
	logic resetBlocks;
	logic paused;
	screenCode screen;

	logic [15:0] ops [$];
	logic [2:0] adrs [$];
	logic [31:0] datas [$];
	logic [31:0] expects [$];
	logic [31:0] saved [4]; // Read values kept for later compares.
	bit loaded = 1'b0;

	tetrisTop i_tetrisTop (
		.Clk(Clk),
		.rst(rst),
		.bus(bus),
		.hitBottom(hitBottom),
		.endGame(endGame),
		.rsp(rsp),
		.resetBlocks(resetBlocks),
		.paused(paused),
		.screen(screen)
	);

	initial Clk = 1'b0;
	always #50 Clk = ~Clk;

	task automatic stopWithFailure();
		$display("TESTS FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail %s: got %h, expected %h", name, actual, expected);
			stopWithFailure();
		end
	endtask

	// Playfield pins carry the same flags as the status word.
	task automatic matchPlayfieldOutputs(input logic [31:0] expectedStatus);
		checkValue("screen", {30'h0, screen}, {30'h0, expectedStatus[4:3]});
		checkValue("paused", {31'h0, paused}, {31'h0, expectedStatus[2]});
		checkValue("resetBlocks", {31'h0, resetBlocks}, {31'h0, expectedStatus[1]});
	endtask

	// One classic cycle, held until ack; stb drops right after it.
	task automatic busCycle(input logic write, input logic [2:0] adr, input logic [31:0] dat,
		output logic [31:0] readData);
		@(posedge Clk);
		#5;
		bus.cyc = 1'b1;
		bus.stb = 1'b1;
		bus.we = write;
		bus.adr = adr;
		bus.dat = dat;
		bus.sel = 4'hF;
		@(posedge Clk);
		#5;
		while (!rsp.ack)
		begin
			@(posedge Clk);
			#5;
		end
		readData = rsp.dat;
		bus.cyc = 1'b0;
		bus.stb = 1'b0;
		bus.we = 1'b0;
	endtask

	// Key press is a write of the code, then a release with 0.
	task automatic pressKey(input logic [31:0] key);
		logic [31:0] unused;
		busCycle(1'b1, AdrKey, key, unused);
		busCycle(1'b1, AdrKey, 32'h0, unused);
		repeat (4) @(posedge Clk);
	endtask

	task automatic pulseBottom(input logic endFlag);
		@(posedge Clk);
		#5;
		hitBottom = 1'b1;
		endGame = endFlag;
		@(posedge Clk);
		#5;
		hitBottom = 1'b0; // endGame stays up through Bottom.
		@(posedge Clk);
		#5;
		endGame = 1'b0;
		repeat (4) @(posedge Clk);
	endtask

	task automatic loadStimulus();
		int fd;
		int code;
		int ch;
		logic [15:0] opWord;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("tests/tetris_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("The stimulus file tests/tetris_stimulus.txt could not be opened.");
			stopWithFailure();
		end
		code = $fscanf(fd, "%s", opWord);
		while (code == 1)
		begin
			if (opWord[7:0] == "#")
			begin
				ch = $fgetc(fd); // Rest of a comment line.
				while (ch != "\n" && ch != -1)
					ch = $fgetc(fd);
			end
			else
			begin
				code = $fscanf(fd, "%h %h %h", a, d, e);
				if (code != 3)
				begin
					$display("Stimulus step %0d is incomplete.", ops.size());
					stopWithFailure();
				end
				ops.push_back(opWord);
				adrs.push_back(a[2:0]);
				datas.push_back(d);
				expects.push_back(e);
			end
			code = $fscanf(fd, "%s", opWord);
		end
		$fclose(fd);
		loaded = 1'b1;
	endtask

	task automatic runStep(input int n);
		logic [2:0] adr;
		logic [31:0] data;
		logic [31:0] value;
		string name;
		adr = adrs[n];
		data = datas[n];
		name = $sformatf("rsp.dat (address %0d)", adr);
		case (ops[n])
			"wr": busCycle(1'b1, adr, data, value);
			"rd":
			begin
				busCycle(1'b0, adr, 32'h0, value);
				checkValue(name, value & data, expects[n]); // Data field is the mask.
				if (adr == AdrStatus && data[4:1] == 4'hF)
					matchPlayfieldOutputs(expects[n]);
			end
			"ky": pressKey(data);
			"hb": pulseBottom(data[0]);
			"sv":
			begin
				busCycle(1'b0, adr, 32'h0, value);
				saved[data[1:0]] = value;
			end
			"eq":
			begin
				busCycle(1'b0, adr, 32'h0, value);
				checkValue(name, value, saved[data[1:0]]);
			end
			"pc":
			begin
				busCycle(1'b0, adr, 32'h0, value);
				checkValue({name, " upper bits"}, value & 32'hFFC0_0000, 32'h0);
				checkValue({name, " shape nonzero"}, {31'h0, value[21:6] != 16'h0}, 32'h1);
				checkValue({name, " sprite 1 to 7"},
					{31'h0, value[5:0] >= 6'd1 && value[5:0] <= 6'd7}, 32'h1);
			end
			default:
			begin
				$display("Stimulus step %0d has an unknown operation.", n);
				stopWithFailure();
			end
		endcase
	endtask

	initial
	begin
		wait (loaded);
		repeat (ops.size() * 20 + 100) @(posedge Clk);
		$display("The run timed out before all stimulus steps finished.");
		stopWithFailure();
	end

	initial
	begin
		int i;
		rst = 1'b1;
		bus = '0;
		hitBottom = 1'b0;
		endGame = 1'b0;
		loadStimulus();
		repeat (8) @(posedge Clk);
		#5;
		rst = 1'b0;
		for (i = 0; i < ops.size(); i++)
			runStep(i);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* tests/tetris_stimulus.txt */
# op adr data expect. wr and rd are bus cycles, rd compares read data under the mask in data.
# ky presses and releases key data, hb pulses hitBottom with endGame data, sv saves a read in slot data, eq compares with it, pc checks a piece.
rd 1 ffffffff 00000017
rd 5 ffffffff 00000000
wr 3 000000ff 00000000
rd 0 ffffffff 00000000
ky 0 0000002c 00000000
rd 1 ffffffff 00010061
rd 5 ffffffff 00010001
pc 2 00000000 00000000
sv 2 00000000 00000000
ky 0 0000002b 00000000
eq 3 00000000 00000000
rd 1 ffffffff 00010060
sv 2 00000001 00000000
ky 0 0000002b 00000000
eq 3 00000000 00000000
eq 2 00000001 00000000
rd 5 ffffffff 00010101
hb 0 00000000 00000000
rd 1 ffffffff 00020061
pc 2 00000000 00000000
sv 2 00000001 00000000
ky 0 0000002b 00000000
eq 3 00000001 00000000
eq 2 00000000 00000000
rd 5 ffffffff 00020201
ky 0 00000013 00000000
rd 1 ffffffff 000200cc
ky 0 0000002c 00000000
ky 0 0000002b 00000000
ky 0 00000029 00000000
rd 1 ffffffff 000200cc
ky 0 00000018 00000000
rd 1 ffffffff 00020060
hb 0 00000001 00000000
rd 1 ffffffff 000200ff
ky 0 00000029 00000000
rd 1 ffffffff 00020017
ky 0 0000002c 00000000
rd 1 ffffffff 00030061
rd 5 ffffffff 00030202
ky 0 00000029 00000000
rd 1 ffffffff 00030017
rd 5 ffffffff 00030202

/* build.f */
source/gamePkg.sv
source/busPkg.sv
source/hostPort.sv
source/pieceSource.sv
source/gameControl.sv
source/gameStatus.sv
source/tetrisTop.sv
tests/tetris_assertions.sv
tests/tetrisTb.sv

/* Makefile */
SRC := $(wildcard source/*.sv tests/*.sv)

.PHONY: run clean

run: obj_dir/simTetris tests/tetris_stimulus.txt
	-./obj_dir/simTetris > sim.log 2>&1
	cat sim.log
	! grep -q "TESTS FAILED" sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/simTetris: build.f $(SRC)
	verilator --binary --timing --assert --top-module tetrisTb -f build.f -o simTetris

clean:
	rm -rf obj_dir sim.log
